//--- common/cpu_bus_if.sv
`timescale 1ns/100ps

interface cpu_bus_if;
    import msx_pkg::*;

    // Address and write data from the CPU
    cpu_addr_t addr;
    byte_t     data;

    // Level strobes, all active high
    logic      rd;
    logic      wr;
    logic      iorq;
    logic      m1;
    logic      mreq;

    // Qualifies a write so that each strobe only commits once
    logic      req;

    // The port decoder needs the low address byte and every I/O strobe
    modport decode_mp (
        input addr, rd, wr, iorq, m1, req
    );

    // A register bank only sees the address for indexing and the write data
    modport regs_mp (
        input addr, data
    );

    // The RAM side only reacts to memory cycles
    modport mem_mp (
        input addr, data, rd, wr, mreq, req
    );

endinterface

//--- common/msx_pkg.sv
package msx_pkg;

    // Byte on the Z80 data bus
    // Every I/O readback and every RAM cell has this width
    typedef logic [7:0] byte_t;

    // Full Z80 address as seen on the CPU bus
    typedef logic [15:0] cpu_addr_t;

    // Segment number as it sits in a mapper register
    // Only the low bits reach physical RAM, the rest wrap
    typedef logic [7:0] seg_t;

    // Index of one of the four 16 KB pages, taken from address bits 15:14
    typedef logic [1:0] page_t;

    // Selects one mapper device, the value 3 means no device
    typedef logic [1:0] dev_sel_t;

    // Number of mapper devices in the core
    // Port, mask and size vectors carry one byte per device
    localparam int NUM_MAPPERS = 3;

    // Address bits that stay inside one 16 KB page
    localparam int PAGE_BITS = 14;

endpackage

//--- mapper/mapper_port_decode.sv
`timescale 1ns/100ps

module mapper_port_decode (
    cpu_bus_if.decode_mp                      bus,
    input  logic [msx_pkg::NUM_MAPPERS-1:0]   mapper_enable,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_port,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_mask,
    output logic [msx_pkg::NUM_MAPPERS-1:0]   reg_wr,
    output logic [msx_pkg::NUM_MAPPERS-1:0]   reg_rd
);
    import msx_pkg::*;

    localparam int BYTE_BITS = $bits(byte_t);

    // An I/O cycle is iorq without m1
    // With m1 high the CPU is doing an interrupt acknowledge instead
    logic                   io_cycle;
    byte_t                  io_port;
    logic [NUM_MAPPERS-1:0] port_hit;

    assign io_cycle = bus.iorq && !bus.m1;

    // Z80 I/O ports live in the low address byte
    assign io_port = bus.addr[BYTE_BITS-1:0];

    // Each device compares on its own, so two devices may share a port
    // and both of them then receive the strobe
    generate
        for (genvar i = 0; i < NUM_MAPPERS; i++) begin : g_dev
            byte_t dev_port;
            byte_t dev_mask;

            // Device 0 sits in the low byte of each configuration vector
            assign dev_port = mapper_port[i*BYTE_BITS +: BYTE_BITS];
            assign dev_mask = mapper_mask[i*BYTE_BITS +: BYTE_BITS];

            // A disabled device never matches, whatever its port says
            assign port_hit[i] = mapper_enable[i] && ((io_port & dev_mask) == dev_port);

            // Writes also need req so a long wr pulse only commits once
            assign reg_wr[i] = io_cycle && port_hit[i] && bus.wr && bus.req;

            // Readback is a plain level and follows rd directly
            assign reg_rd[i] = io_cycle && port_hit[i] && bus.rd;
        end
    endgenerate

endmodule

//--- mapper/mapper_segment_regs.sv
`timescale 1ns/100ps

module mapper_segment_regs (
    input  logic           clk,
    input  logic           reset,
    cpu_bus_if.regs_mp     bus,
    input  logic           wr,
    input  logic           oe,
    input  msx_pkg::seg_t  size,
    output msx_pkg::byte_t q,
    output msx_pkg::seg_t  page_seg
);
    import msx_pkg::*;

    localparam int NUM_PAGES = 1 << $bits(page_t);

    // One segment register per 16 KB page of the CPU address space
    seg_t  seg_reg [NUM_PAGES];

    // Register picked by the I/O port number, ports FC..FF map to pages 0..3
    page_t reg_sel;

    // Page the CPU is currently addressing in memory
    page_t cur_page;

    // Bits that may be set in a segment number for this device size
    seg_t  size_mask;

    assign reg_sel  = bus.addr[$bits(page_t)-1:0];
    assign cur_page = bus.addr[PAGE_BITS +: $bits(page_t)];

    // A size of zero wraps to all ones, which stands for 256 segments
    // Sizes are expected to be powers of two
    assign size_mask = size - 1'b1;

    // Only bits below the size are kept, so a segment can never point
    // past the end of the device
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int p = 0; p < NUM_PAGES; p++) begin
                seg_reg[p] <= '0;
            end
        end else if (wr) begin
            seg_reg[reg_sel] <= bus.data & size_mask;
        end
    end

    // The real hardware returns ones in the unused upper bits
    // Software sizes the mapper by reading these back
    // When not selected the output is all ones so it can be ANDed with
    // the other devices
    assign q = oe ? (seg_reg[reg_sel] | ~size_mask) : '1;

    // Segment used for the memory access at the current address
    assign page_seg = seg_reg[cur_page];

endmodule

//--- mapper/mapper_unit.sv
`timescale 1ns/100ps

module mapper_unit (
    input  logic                              clk,
    input  logic                              reset,
    cpu_bus_if                                bus,
    input  logic [msx_pkg::NUM_MAPPERS-1:0]   mapper_enable,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_port,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_mask,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_size,
    input  msx_pkg::dev_sel_t                 active_mapper,
    output msx_pkg::byte_t                    io_data,
    output msx_pkg::seg_t                     seg
);
    import msx_pkg::*;

    localparam int SEG_W = $bits(seg_t);

    // Per-device strobes from the port decoder
    logic [NUM_MAPPERS-1:0] reg_wr;
    logic [NUM_MAPPERS-1:0] reg_rd;

    // Per-device readback and page segment
    byte_t dev_q   [NUM_MAPPERS];
    seg_t  dev_seg [NUM_MAPPERS];

    mapper_port_decode i_port_decode (
        .bus           (bus),
        .mapper_enable (mapper_enable),
        .mapper_port   (mapper_port),
        .mapper_mask   (mapper_mask),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd)
    );

    // All banks see the same bus, only their strobes and sizes differ
    generate
        for (genvar i = 0; i < NUM_MAPPERS; i++) begin : g_regs
            mapper_segment_regs i_segment_regs (
                .clk      (clk),
                .reset    (reset),
                .bus      (bus),
                .wr       (reg_wr[i]),
                .oe       (reg_rd[i]),
                .size     (mapper_size[i*SEG_W +: SEG_W]),
                .q        (dev_q[i]),
                .page_seg (dev_seg[i])
            );
        end
    endgenerate

    // Idle banks return all ones, so ANDing them acts like an open
    // collector bus where any selected device can pull bits low
    always_comb begin
        io_data = '1;
        for (int j = 0; j < NUM_MAPPERS; j++) begin
            io_data = io_data & dev_q[j];
        end
    end

    // Only one device drives the memory side
    // The spare select value leaves the segment at all ones
    assign seg = (active_mapper < NUM_MAPPERS) ? dev_seg[active_mapper] : '1;

endmodule

//--- msx_mapper.f
common/msx_pkg.sv
common/cpu_bus_if.sv
mapper/mapper_port_decode.sv
mapper/mapper_segment_regs.sv
mapper/mapper_unit.sv
rtl/mapper_ram.sv
rtl/msx_mapper_top.sv
testbench/msx_mapper_checker.sv
testbench/msx_mapper_tb.sv

//--- rtl/mapper_ram.sv
`timescale 1ns/100ps

module mapper_ram #(
    parameter int SEG_BITS = 3
) (
    input  logic           clk,
    input  logic           reset,
    cpu_bus_if.mem_mp      bus,
    input  msx_pkg::seg_t  seg,
    output msx_pkg::byte_t mem_data
);
    import msx_pkg::*;

    // Physical address is segment bits on top of the page offset
    localparam int PHYS_BITS = SEG_BITS + PAGE_BITS;
    localparam int MEM_DEPTH = 1 << PHYS_BITS;

    logic [PHYS_BITS-1:0] phys_addr;
    logic                 mem_wr;
    logic                 mem_rd;

    // Byte-wide RAM, MEM_DEPTH bytes in total
    // With the default three segment bits this is 128 KB
    byte_t mem [MEM_DEPTH];

    // Segment bits above SEG_BITS are dropped here, so a large
    // segment number wraps around inside the installed RAM
    assign phys_addr = {seg[SEG_BITS-1:0], bus.addr[PAGE_BITS-1:0]};

    // A memory write needs req, just like a register write
    assign mem_wr = bus.mreq && bus.wr && bus.req;

    // Reads follow the plain rd level
    assign mem_rd = bus.mreq && bus.rd;

    // The write uses the segment that is valid before this edge, so a
    // segment register written in the same cycle does not affect it
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[phys_addr] <= bus.data;
        end
    end

    // Read data appears one cycle after the read condition and then
    // holds until the next memory read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_data <= '0;
        end else if (mem_rd) begin
            mem_data <= mem[phys_addr];
        end
    end

endmodule

//--- rtl/msx_mapper_top.sv
`timescale 1ns/100ps

module msx_mapper_top #(
    parameter int SEG_BITS = 3
) (
    input  logic                              clk,
    input  logic                              reset,

    // CPU bus
    input  msx_pkg::cpu_addr_t                addr,
    input  msx_pkg::byte_t                    data,
    input  logic                              rd,
    input  logic                              wr,
    input  logic                              iorq,
    input  logic                              m1,
    input  logic                              mreq,
    input  logic                              req,

    // Runtime configuration, one byte per device with device 0 lowest
    input  logic [msx_pkg::NUM_MAPPERS-1:0]   mapper_enable,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_port,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_mask,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_size,
    input  msx_pkg::dev_sel_t                 active_mapper,

    // Combinational I/O readback and registered RAM read data
    output msx_pkg::byte_t                    io_data,
    output msx_pkg::byte_t                    mem_data
);
    import msx_pkg::*;

    // Segment of the active device for the page being addressed
    seg_t seg;

    cpu_bus_if bus ();

    // The bus interface is fed straight from the pins
    assign bus.addr = addr;
    assign bus.data = data;
    assign bus.rd   = rd;
    assign bus.wr   = wr;
    assign bus.iorq = iorq;
    assign bus.m1   = m1;
    assign bus.mreq = mreq;
    assign bus.req  = req;

    // Port decode and segment registers
    mapper_unit i_mapper_unit (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus),
        .mapper_enable (mapper_enable),
        .mapper_port   (mapper_port),
        .mapper_mask   (mapper_mask),
        .mapper_size   (mapper_size),
        .active_mapper (active_mapper),
        .io_data       (io_data),
        .seg           (seg)
    );

    // Address translation and RAM array
    mapper_ram #(
        .SEG_BITS (SEG_BITS)
    ) i_mapper_ram (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus.mem_mp),
        .seg      (seg),
        .mem_data (mem_data)
    );

endmodule

//--- testbench/msx_mapper_checker.sv
`timescale 1ns/100ps

module msx_mapper_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rd,
    input  logic                              iorq,
    input  logic                              m1,
    input  logic                              mreq,
    input  logic [msx_pkg::NUM_MAPPERS-1:0]   reg_rd,
    input  logic [msx_pkg::NUM_MAPPERS*8-1:0] mapper_size,
    input  msx_pkg::byte_t                    io_data,
    input  msx_pkg::byte_t                    mem_data
);
    import msx_pkg::*;

    // Readback right after reset, when every register is still zero
    // Each read-enabled device then shows only its padding bits
    byte_t       reset_pad;

    // Failed assertions, read by the testbench at the end of the run
    int unsigned fail_count = 0;

    always_comb begin
        reset_pad = '1;
        for (int i = 0; i < NUM_MAPPERS; i++) begin
            if (reg_rd[i]) begin
                reset_pad = reset_pad & ~(mapper_size[i*8 +: 8] - 8'd1);
            end
        end
    end

    // Without an I/O read every device drives all ones
    idle_readback: assert property (@(posedge clk) disable iff (reset)
        !(iorq && !m1 && rd) |-> io_data == 8'hff)
    else begin
        $error("io_data is %02h without an I/O read cycle", io_data);
        fail_count++;
    end

    // Read data only moves at an edge where a memory read was seen
    read_data_hold: assert property (@(posedge clk) disable iff (reset)
        !(mreq && rd) |=> $stable(mem_data))
    else begin
        $error("mem_data changed without a memory read");
        fail_count++;
    end

    // One cycle after reset is released the registers are all zero
    reset_readback: assert property (@(posedge clk)
        $fell(reset) |=> io_data == reset_pad)
    else begin
        $error("io_data is %02h after reset, padding is %02h", io_data, reset_pad);
        fail_count++;
    end

endmodule

//--- testbench/msx_mapper_tb.sv
`timescale 1ns/100ps

module msx_mapper_tb;
    import msx_pkg::*;

    localparam int SEG_BITS     = 3;
    localparam int RESET_CYCLES = 3;

    // Rough length of each test in clock cycles, in the order they run
    localparam int TEST_CYCLES  = RESET_CYCLES + 12 + 4 * 33 + 30 + 30 + 70 + 64;
    localparam int CYCLE_LIMIT  = 4 * TEST_CYCLES;

    logic                       clk;
    logic                       reset;
    cpu_addr_t                  addr;
    byte_t                      data;
    logic                       rd;
    logic                       wr;
    logic                       iorq;
    logic                       m1;
    logic                       mreq;
    logic                       req;
    logic [NUM_MAPPERS-1:0]     mapper_enable;
    logic [NUM_MAPPERS*8-1:0]   mapper_port;
    logic [NUM_MAPPERS*8-1:0]   mapper_mask;
    logic [NUM_MAPPERS*8-1:0]   mapper_size;
    dev_sel_t                   active_mapper;
    byte_t                      io_data;
    byte_t                      mem_data;

    // Reference model of the twelve segment registers and the bytes written so far
    seg_t        seg_model [NUM_MAPPERS][4];
    byte_t       ram_model [int];

    logic [31:0] rng_state;
    int          cycle_count;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    msx_mapper_top #(
        .SEG_BITS (SEG_BITS)
    ) i_msx_mapper_top (
        .clk           (clk),
        .reset         (reset),
        .addr          (addr),
        .data          (data),
        .rd            (rd),
        .wr            (wr),
        .iorq          (iorq),
        .m1            (m1),
        .mreq          (mreq),
        .req           (req),
        .mapper_enable (mapper_enable),
        .mapper_port   (mapper_port),
        .mapper_mask   (mapper_mask),
        .mapper_size   (mapper_size),
        .active_mapper (active_mapper),
        .io_data       (io_data),
        .mem_data      (mem_data)
    );

    bind msx_mapper_top msx_mapper_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .rd          (rd),
        .iorq        (iorq),
        .m1          (m1),
        .mreq        (mreq),
        .reg_rd      (i_mapper_unit.reg_rd),
        .mapper_size (mapper_size),
        .io_data     (io_data),
        .mem_data    (mem_data)
    );

    always #2 clk = ~clk;

    // The watchdog ends the run at a few times its expected length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Devices 0, 1 and 2 answer on FC-FF, F8-FB and F4-F7
    function automatic byte_t dev_base(input int dev);
        return 8'hfc - 8'(4 * dev);
    endfunction

    // Size zero stands for 256 segments, so its mask is all ones
    function automatic byte_t size_mask(input int dev);
        return mapper_size[dev*8 +: 8] - 8'd1;
    endfunction

    function automatic bit port_match(input int dev, input byte_t port);
        return mapper_enable[dev] &&
               ((port & mapper_mask[dev*8 +: 8]) == mapper_port[dev*8 +: 8]);
    endfunction

    // Every matching device answers, and the answers are ANDed
    function automatic byte_t expected_io(input byte_t port);
        byte_t r;
        r = 8'hff;
        for (int d = 0; d < NUM_MAPPERS; d++) begin
            if (port_match(d, port)) begin
                r = r & (seg_model[d][port[1:0]] | ~size_mask(d));
            end
        end
        return r;
    endfunction

    // Physical byte reached through the active device's segment
    function automatic int phys_addr(input cpu_addr_t a);
        seg_t s;
        if (active_mapper == 2'd3) begin
            s = 8'hff;
        end else begin
            s = seg_model[active_mapper][a[15:14]];
        end
        return int'(s & ((1 << SEG_BITS) - 1)) * 16384 + int'(a[13:0]);
    endfunction

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %02h, expected %02h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // Drives one bus cycle and waits for the edge that ends it
    task automatic bus_cycle(input cpu_addr_t a, input byte_t d, input logic rd_v,
                             input logic wr_v, input logic iorq_v, input logic m1_v,
                             input logic mreq_v, input logic req_v);
        addr <= a;
        data <= d;
        rd   <= rd_v;
        wr   <= wr_v;
        iorq <= iorq_v;
        m1   <= m1_v;
        mreq <= mreq_v;
        req  <= req_v;
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic io_write(input byte_t port, input byte_t value);
        bus_cycle({8'h00, port}, value, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        for (int d = 0; d < NUM_MAPPERS; d++) begin
            if (port_match(d, port)) begin
                seg_model[d][port[1:0]] = value & size_mask(d);
            end
        end
    endtask

    // io_data is combinational, so it is sampled at the edge ending the read
    task automatic io_read_check(input byte_t port);
        bus_cycle({8'h00, port}, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        compare_byte("io_data", io_data, expected_io(port));
    endtask

    task automatic check_all_regs();
        for (int d = 0; d < NUM_MAPPERS; d++) begin
            for (int r = 0; r < 4; r++) begin
                io_read_check(dev_base(d) | 8'(r));
            end
        end
    endtask

    task automatic mem_write(input cpu_addr_t a, input byte_t value);
        int pa;
        pa = phys_addr(a);
        bus_cycle(a, value, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
        ram_model[pa] = value;
    endtask

    // Read data is registered, so it is checked one cycle after the strobe
    task automatic mem_read_check(input cpu_addr_t a);
        int pa;
        pa = phys_addr(a);
        bus_cycle(a, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        idle_cycle();
        if (ram_model.exists(pa)) begin
            compare_byte("mem_data", mem_data, ram_model[pa]);
        end else begin
            $display("Error at %0t: address %04h was read before any write", $time, a);
            test_errors++;
        end
    endtask

    task automatic set_sizes(input byte_t s0, input byte_t s1, input byte_t s2);
        mapper_size <= {s2, s1, s0};
        idle_cycle();
    endtask

    task automatic set_ports(input logic [2:0] en, input logic [23:0] port);
        mapper_enable <= en;
        mapper_port   <= port;
        idle_cycle();
    endtask

    task automatic select_mapper(input dev_sel_t dev);
        active_mapper <= dev;
        idle_cycle();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        total_errors += test_errors;
        $display("Test %-16s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic write_readback_test();
        byte_t sizes [4];
        logic [31:0] r;
        byte_t port;
        sizes = '{8'd4, 8'd8, 8'd32, 8'd0};
        // Each round gives every device a different size from the list
        for (int k = 0; k < 4; k++) begin
            set_sizes(sizes[k], sizes[(k + 1) % 4], sizes[(k + 2) % 4]);
            repeat (16) begin
                r = rand32();
                port = dev_base(int'(r[9:8]) % 3) | 8'(r[1:0]);
                io_write(port, r[23:16]);
                io_read_check(port);
            end
        end
    endtask

    task automatic decode_reject_test();
        logic [31:0] r;
        r = rand32();
        // Interrupt acknowledge, m1 high during iorq
        bus_cycle(16'h00fd, r[7:0], 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
        bus_cycle(16'h00fd, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        compare_byte("io_data", io_data, 8'hff);
        // Port 7D differs from FD only in a bit that the mask keeps
        bus_cycle(16'h007d, r[15:8], 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        bus_cycle(16'h007d, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        compare_byte("io_data", io_data, 8'hff);
        // Device 2 switched off
        set_ports(3'b011, {8'hf4, 8'hf8, 8'hfc});
        bus_cycle(16'h00f5, r[23:16], 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        bus_cycle(16'h00f5, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        compare_byte("io_data", io_data, 8'hff);
        set_ports(3'b111, {8'hf4, 8'hf8, 8'hfc});
        // Write strobe without req
        bus_cycle(16'h00fe, r[31:24], 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        check_all_regs();
    endtask

    task automatic shared_ports_test();
        logic [31:0] r;
        // Device 1 moves onto device 0's ports with a larger size
        set_sizes(8'd8, 8'd32, 8'd0);
        set_ports(3'b111, {8'hf4, 8'hfc, 8'hfc});
        for (int k = 0; k < 4; k++) begin
            r = rand32();
            io_write(8'hfc | 8'(k), r[7:0]);
        end
        for (int k = 0; k < 4; k++) begin
            io_read_check(8'hfc | 8'(k));
        end
        // Back on its own ports device 1 shows what it took in
        set_ports(3'b111, {8'hf4, 8'hf8, 8'hfc});
        check_all_regs();
    endtask

    task automatic memory_test();
        cpu_addr_t addrs [$];
        cpu_addr_t a;
        logic [31:0] r;
        set_sizes(8'd0, 8'd0, 8'd8);
        select_mapper(2'd0);
        for (int k = 0; k < 4; k++) begin
            r = rand32();
            io_write(8'hfc | 8'(k), r[7:0]);
        end
        repeat (16) begin
            r = rand32();
            a = r[15:0];
            mem_write(a, r[23:16]);
            addrs.push_back(a);
        end
        foreach (addrs[k]) begin
            mem_read_check(addrs[k]);
        end
        // Same CPU address under two segments holds two different bytes
        r = rand32();
        a = r[15:0];
        io_write(8'hfc | 8'(a[15:14]), r[23:16]);
        mem_write(a, 8'h5a);
        io_write(8'hfc | 8'(a[15:14]), r[23:16] + 8'd1);
        mem_write(a, 8'ha5);
        mem_read_check(a);
        io_write(8'hfc | 8'(a[15:14]), r[23:16]);
        mem_read_check(a);
    endtask

    task automatic active_select_test();
        cpu_addr_t addrs [$];
        logic [31:0] r;
        // Device 1 points every page one segment further than device 0
        for (int k = 0; k < 4; k++) begin
            io_write(8'hf8 | 8'(k), seg_model[0][k] + 8'd1);
        end
        repeat (8) begin
            r = rand32();
            addrs.push_back(r[15:0]);
            mem_write(r[15:0], r[23:16]);
        end
        select_mapper(2'd1);
        foreach (addrs[k]) begin
            mem_write(addrs[k], ~addrs[k][7:0]);
        end
        foreach (addrs[k]) begin
            mem_read_check(addrs[k]);
        end
        select_mapper(2'd0);
        foreach (addrs[k]) begin
            mem_read_check(addrs[k]);
        end
        // The spare select value reaches the top segment
        select_mapper(2'd3);
        mem_write(addrs[0], 8'h3c);
        mem_read_check(addrs[0]);
    endtask

    initial begin
        int checker_fails;
        clk           = 1'b0;
        reset         = 1'b1;
        addr          = '0;
        data          = '0;
        rd            = 1'b0;
        wr            = 1'b0;
        iorq          = 1'b0;
        m1            = 1'b0;
        mreq          = 1'b0;
        req           = 1'b0;
        mapper_enable = 3'b111;
        mapper_port   = {8'hf4, 8'hf8, 8'hfc};
        mapper_mask   = {8'hfc, 8'hfc, 8'hfc};
        mapper_size   = {8'd0, 8'd4, 8'd8};
        active_mapper = 2'd0;
        rng_state     = 32'h433b;
        cycle_count   = 0;
        test_errors   = 0;
        total_errors  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        foreach (seg_model[d, p]) begin
            seg_model[d][p] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // Reads start right away so the reset readback is observed
        check_all_regs();
        finish_test("reset_state");
        write_readback_test();
        finish_test("write_readback");
        decode_reject_test();
        finish_test("decode_reject");
        shared_ports_test();
        finish_test("shared_ports");
        memory_test();
        finish_test("memory");
        active_select_test();
        finish_test("active_select");
        idle_cycle();
        checker_fails = i_msx_mapper_top.i_checker.fail_count;
        $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, total_errors, checker_fails);
        if (total_errors == 0 && checker_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
